//--- logic/rv_core_settings.svh
// --------------------
// RISC-V core settings
// Word width, register file size, reset PC and stream CSR numbers
// --------------------

`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// Datapath word width
`define RV_XLEN 32

// Architectural integer registers
`define RV_NUM_REGS 32

// Address of the first fetch after reset
`define RV_RESET_PC 32'h0000_0200

// Manager stream CSRs
`define RV_CSR_MNGR2PROC 12'hFC0
`define RV_CSR_PROC2MNGR 12'h7C0

`endif

//--- logic/rv_core_pkg.sv
// --------------------
// RISC-V core package
// Word, register index, instruction formats and operation codes
// --------------------

`include "rv_core_settings.svh"

package rv_core_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;

  // --------------------
  // Instruction formats
  // --------------------

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // Stores and branches share the split immediate layout
  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_b_fmt_t;

  typedef struct packed {
    logic [19:0] imm20;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_j_fmt_t;

  // One instruction word, viewed through the format its opcode selects
  typedef union packed {
    r_fmt_t   r_fmt;
    i_fmt_t   i_fmt;
    s_b_fmt_t s_b_fmt;
    u_j_fmt_t u_j_fmt;
  } inst_u;

  // --------------------
  // Operation codes
  // --------------------

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
    ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU} br_op_e;

  typedef enum logic [2:0] {
    CLS_ALU, CLS_BRANCH, CLS_JAL, CLS_CSR_READ, CLS_CSR_WRITE, CLS_NOP
  } inst_class_e;

endpackage

//--- logic/rv_regfile.sv
// --------------------
// Integer register file
// Two combinational read ports, one write port, x0 reads zero
// --------------------

`timescale 1ns/10ps
`include "rv_core_settings.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  reset,
  input  rv_core_pkg::reg_idx_t rs1_i,
  input  rv_core_pkg::reg_idx_t rs2_i,
  output rv_core_pkg::word_t    rs1_data_o,
  output rv_core_pkg::word_t    rs2_data_o,
  input  logic                  wen_i,
  input  rv_core_pkg::reg_idx_t waddr_i,
  input  rv_core_pkg::word_t    wdata_i
);
  import rv_core_pkg::*;

  word_t regs [`RV_NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rs1_data_o = regs[rs1_i];
  assign rs2_data_o = regs[rs2_i];

endmodule

//--- logic/rv_alu.sv
// --------------------
// Integer ALU
// Arithmetic, logic and shift results plus the branch comparison
// --------------------

`timescale 1ns/10ps

module rv_alu (
  input  rv_core_pkg::word_t   rs1_data_i,
  input  rv_core_pkg::word_t   rs2_data_i,
  input  rv_core_pkg::word_t   imm_i,
  input  logic                 use_imm_i,
  input  rv_core_pkg::alu_op_e alu_op_i,
  input  rv_core_pkg::br_op_e  br_op_i,
  output rv_core_pkg::word_t   result_o,
  output logic                 br_taken_o
);
  import rv_core_pkg::*;

  word_t      op_b;
  logic [4:0] shamt;

  assign op_b  = use_imm_i ? imm_i : rs2_data_i;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op_i)
      ALU_ADD:    result_o = rs1_data_i + op_b;
      ALU_SUB:    result_o = rs1_data_i - op_b;
      ALU_AND:    result_o = rs1_data_i & op_b;
      ALU_OR:     result_o = rs1_data_i | op_b;
      ALU_XOR:    result_o = rs1_data_i ^ op_b;
      ALU_SLT:    result_o = word_t'($signed(rs1_data_i) < $signed(op_b));
      ALU_SLTU:   result_o = word_t'(rs1_data_i < op_b);
      ALU_SLL:    result_o = rs1_data_i << shamt;
      ALU_SRL:    result_o = rs1_data_i >> shamt;
      ALU_SRA:    result_o = word_t'($signed(rs1_data_i) >>> shamt);
      ALU_PASS_B: result_o = op_b;
      default:    result_o = rs1_data_i + op_b;
    endcase
  end

  // Branches always compare the two registers
  always_comb begin
    case (br_op_i)
      BR_EQ:   br_taken_o = (rs1_data_i == rs2_data_i);
      BR_NE:   br_taken_o = (rs1_data_i != rs2_data_i);
      BR_LT:   br_taken_o = ($signed(rs1_data_i) < $signed(rs2_data_i));
      BR_GE:   br_taken_o = ($signed(rs1_data_i) >= $signed(rs2_data_i));
      BR_LTU:  br_taken_o = (rs1_data_i < rs2_data_i);
      BR_GEU:  br_taken_o = (rs1_data_i >= rs2_data_i);
      default: br_taken_o = 1'b0;
    endcase
  end

endmodule

//--- logic/rv_inst_decode.sv
// --------------------
// Instruction decoder
// Holds the fetched word and derives class, registers, immediate and ops
// --------------------

`timescale 1ns/10ps
`include "rv_core_settings.svh"

module rv_inst_decode (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     inst_load_i,
  input  rv_core_pkg::word_t       inst_i,
  output rv_core_pkg::inst_class_e class_o,
  output logic                     is_stream_csr_o,
  output rv_core_pkg::reg_idx_t    rd_o,
  output rv_core_pkg::reg_idx_t    rs1_o,
  output rv_core_pkg::reg_idx_t    rs2_o,
  output rv_core_pkg::word_t       imm_o,
  output logic                     use_imm_o,
  output rv_core_pkg::alu_op_e     alu_op_o,
  output rv_core_pkg::br_op_e      br_op_o
);
  import rv_core_pkg::*;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
  localparam logic [2:0] F3_CSRRW   = 3'b001;
  localparam logic [2:0] F3_CSRRS   = 3'b010;

  inst_u      inst_q;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_op;
  logic       is_shift;
  logic       alt_op;
  logic       funct7_ok;
  word_t      imm_i_type;
  word_t      imm_shamt;
  word_t      imm_b_type;
  word_t      imm_u_type;
  word_t      imm_j_type;

  // Instruction register resets to a no-op
  always_ff @(posedge clk) begin
    if (reset) begin
      inst_q <= '0;
    end else if (inst_load_i) begin
      inst_q <= inst_i;
    end
  end

  assign funct3   = inst_q.r_fmt.funct3;
  assign funct7   = inst_q.r_fmt.funct7;
  assign rd_o     = inst_q.r_fmt.rd;
  assign rs1_o    = inst_q.r_fmt.rs1;
  assign rs2_o    = inst_q.r_fmt.rs2;
  assign is_op    = (inst_q.r_fmt.opcode == OPC_OP);
  assign is_shift = (funct3[1:0] == 2'b01);

  // Bit 30 picks sub and sra; addi has no alternate form
  assign alt_op    = funct7[5] && (is_op || funct3 == 3'b101);
  assign funct7_ok = (funct7 == 7'b0000000) ||
                     (funct7 == 7'b0100000 && (funct3 == 3'b101 || (is_op && funct3 == 3'b000)));

  // Sign-extended immediates per format
  assign imm_i_type = {{20{inst_q.i_fmt.imm12[11]}}, inst_q.i_fmt.imm12};
  assign imm_shamt  = {27'b0, inst_q.r_fmt.rs2};
  assign imm_b_type = {{20{inst_q.s_b_fmt.imm_hi[6]}}, inst_q.s_b_fmt.imm_lo[0],
                       inst_q.s_b_fmt.imm_hi[5:0], inst_q.s_b_fmt.imm_lo[4:1], 1'b0};
  assign imm_u_type = {inst_q.u_j_fmt.imm20, 12'b0};
  assign imm_j_type = {{12{inst_q.u_j_fmt.imm20[19]}}, inst_q.u_j_fmt.imm20[7:0],
                       inst_q.u_j_fmt.imm20[8], inst_q.u_j_fmt.imm20[18:9], 1'b0};

  always_comb begin
    class_o         = CLS_NOP;
    is_stream_csr_o = 1'b0;
    imm_o           = imm_i_type;
    use_imm_o       = 1'b0;
    br_op_o         = BR_EQ;
    case (funct3)
      3'b000:  alu_op_o = alt_op ? ALU_SUB : ALU_ADD;
      3'b001:  alu_op_o = ALU_SLL;
      3'b010:  alu_op_o = ALU_SLT;
      3'b011:  alu_op_o = ALU_SLTU;
      3'b100:  alu_op_o = ALU_XOR;
      3'b101:  alu_op_o = alt_op ? ALU_SRA : ALU_SRL;
      3'b110:  alu_op_o = ALU_OR;
      default: alu_op_o = ALU_AND;
    endcase
    case (inst_q.r_fmt.opcode)
      OPC_OP: begin
        class_o = funct7_ok ? CLS_ALU : CLS_NOP;
      end
      OPC_OP_IMM: begin
        class_o   = (!is_shift || funct7_ok) ? CLS_ALU : CLS_NOP;
        use_imm_o = 1'b1;
        imm_o     = is_shift ? imm_shamt : imm_i_type;
      end
      OPC_LUI: begin
        class_o   = CLS_ALU;
        use_imm_o = 1'b1;
        imm_o     = imm_u_type;
        alu_op_o  = ALU_PASS_B;
      end
      OPC_BRANCH: begin
        class_o = CLS_BRANCH;
        imm_o   = imm_b_type;
        case (funct3)
          3'b000:  br_op_o = BR_EQ;
          3'b001:  br_op_o = BR_NE;
          3'b100:  br_op_o = BR_LT;
          3'b101:  br_op_o = BR_GE;
          3'b110:  br_op_o = BR_LTU;
          3'b111:  br_op_o = BR_GEU;
          default: class_o = CLS_NOP;
        endcase
      end
      OPC_JAL: begin
        class_o = CLS_JAL;
        imm_o   = imm_j_type;
      end
      OPC_SYSTEM: begin
        // csrr is csrrs with x0 and csrw is csrrw to x0
        if (funct3 == F3_CSRRS) begin
          class_o         = CLS_CSR_READ;
          is_stream_csr_o = (inst_q.i_fmt.imm12 == `RV_CSR_MNGR2PROC);
        end else if (funct3 == F3_CSRRW) begin
          class_o         = CLS_CSR_WRITE;
          is_stream_csr_o = (inst_q.i_fmt.imm12 == `RV_CSR_PROC2MNGR);
        end
      end
      default: begin
        class_o = CLS_NOP;
      end
    endcase
  end

endmodule

//--- logic/rv_core_ctrl.sv
// --------------------
// Core control
// Fetch/execute FSM, PC, stream handshakes and write-back select
// --------------------

`timescale 1ns/10ps
`include "rv_core_settings.svh"

module rv_core_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  output rv_core_pkg::word_t       imem_req_addr_o,
  output logic                     imem_req_val_o,
  input  logic                     imem_req_rdy_i,
  input  logic                     imem_resp_val_i,
  output logic                     imem_resp_rdy_o,
  input  rv_core_pkg::word_t       mngr2proc_msg_i,
  input  logic                     mngr2proc_val_i,
  output logic                     mngr2proc_rdy_o,
  output logic                     proc2mngr_val_o,
  input  logic                     proc2mngr_rdy_i,
  output logic                     inst_load_o,
  input  rv_core_pkg::inst_class_e class_i,
  input  logic                     is_stream_csr_i,
  input  rv_core_pkg::word_t       imm_i,
  input  logic                     br_taken_i,
  input  rv_core_pkg::word_t       alu_result_i,
  output logic                     rf_wen_o,
  output rv_core_pkg::word_t       rf_wdata_o
);
  import rv_core_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_IREQ, ST_IWAIT, ST_EXEC} state_e;

  state_e state_q;
  state_e state_d;
  word_t  pc_q;
  word_t  pc_plus4;
  logic   csr_read;
  logic   csr_write;
  logic   exec_done;
  logic   redirect;

  assign pc_plus4  = pc_q + word_t'(4);
  assign csr_read  = (class_i == CLS_CSR_READ) && is_stream_csr_i;
  assign csr_write = (class_i == CLS_CSR_WRITE) && is_stream_csr_i;
  assign redirect  = (class_i == CLS_JAL) || (class_i == CLS_BRANCH && br_taken_i);

  // --------------------
  // Stream handshakes
  // --------------------

  assign imem_req_addr_o = pc_q;
  assign imem_req_val_o  = (state_q == ST_IREQ);
  assign imem_resp_rdy_o = (state_q == ST_IWAIT);
  assign inst_load_o     = imem_resp_rdy_o && imem_resp_val_i;
  assign mngr2proc_rdy_o = (state_q == ST_EXEC) && csr_read;
  assign proc2mngr_val_o = (state_q == ST_EXEC) && csr_write;

  // Exec stalls while a stream CSR has no partner
  assign exec_done = (state_q == ST_EXEC) && !(csr_read && !mngr2proc_val_i) &&
                     !(csr_write && !proc2mngr_rdy_i);

  // Write-back
  assign rf_wen_o = exec_done && (class_i == CLS_ALU || class_i == CLS_JAL || csr_read);

  always_comb begin
    case (class_i)
      CLS_JAL:      rf_wdata_o = pc_plus4;
      CLS_CSR_READ: rf_wdata_o = mngr2proc_msg_i;
      default:      rf_wdata_o = alu_result_i;
    endcase
  end

  // --------------------
  // FSM and PC
  // --------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: state_d = ST_IREQ;
      ST_IREQ: begin
        if (imem_req_rdy_i) begin
          state_d = ST_IWAIT;
        end
      end
      ST_IWAIT: begin
        if (imem_resp_val_i) begin
          state_d = ST_EXEC;
        end
      end
      default: begin
        if (exec_done) begin
          state_d = ST_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
      pc_q    <= `RV_RESET_PC;
    end else begin
      state_q <= state_d;
      if (exec_done) begin
        pc_q <= redirect ? pc_q + imm_i : pc_plus4;
      end
    end
  end

endmodule

//--- logic/rv_core.sv
// --------------------
// Multicycle RISC-V core
// Control FSM with decode, register file and ALU datapath
// --------------------

`timescale 1ns/10ps

module rv_core (
  input  logic               clk,
  input  logic               reset,

  // Instruction fetch request and response
  output rv_core_pkg::word_t imem_req_addr_o,
  output logic               imem_req_val_o,
  input  logic               imem_req_rdy_i,
  input  rv_core_pkg::word_t imem_resp_data_i,
  input  logic               imem_resp_val_i,
  output logic               imem_resp_rdy_o,

  // Manager streams
  input  rv_core_pkg::word_t mngr2proc_msg_i,
  input  logic               mngr2proc_val_i,
  output logic               mngr2proc_rdy_o,
  output rv_core_pkg::word_t proc2mngr_msg_o,
  output logic               proc2mngr_val_o,
  input  logic               proc2mngr_rdy_i
);
  import rv_core_pkg::*;

  logic        inst_load;
  inst_class_e inst_class;
  logic        is_stream_csr;
  reg_idx_t    rd;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  word_t       imm;
  logic        use_imm;
  alu_op_e     alu_op;
  br_op_e      br_op;
  word_t       rs1_data;
  word_t       rs2_data;
  word_t       alu_result;
  logic        br_taken;
  logic        rf_wen;
  word_t       rf_wdata;

  // csrw sends rs1 straight out
  assign proc2mngr_msg_o = rs1_data;

  rv_core_ctrl i_ctrl (
    .clk             (clk),
    .reset           (reset),
    .imem_req_addr_o (imem_req_addr_o),
    .imem_req_val_o  (imem_req_val_o),
    .imem_req_rdy_i  (imem_req_rdy_i),
    .imem_resp_val_i (imem_resp_val_i),
    .imem_resp_rdy_o (imem_resp_rdy_o),
    .mngr2proc_msg_i (mngr2proc_msg_i),
    .mngr2proc_val_i (mngr2proc_val_i),
    .mngr2proc_rdy_o (mngr2proc_rdy_o),
    .proc2mngr_val_o (proc2mngr_val_o),
    .proc2mngr_rdy_i (proc2mngr_rdy_i),
    .inst_load_o     (inst_load),
    .class_i         (inst_class),
    .is_stream_csr_i (is_stream_csr),
    .imm_i           (imm),
    .br_taken_i      (br_taken),
    .alu_result_i    (alu_result),
    .rf_wen_o        (rf_wen),
    .rf_wdata_o      (rf_wdata)
  );

  rv_inst_decode i_decode (
    .clk             (clk),
    .reset           (reset),
    .inst_load_i     (inst_load),
    .inst_i          (imem_resp_data_i),
    .class_o         (inst_class),
    .is_stream_csr_o (is_stream_csr),
    .rd_o            (rd),
    .rs1_o           (rs1),
    .rs2_o           (rs2),
    .imm_o           (imm),
    .use_imm_o       (use_imm),
    .alu_op_o        (alu_op),
    .br_op_o         (br_op)
  );

  rv_regfile i_regfile (
    .clk        (clk),
    .reset      (reset),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wen_i      (rf_wen),
    .waddr_i    (rd),
    .wdata_i    (rf_wdata)
  );

  rv_alu i_alu (
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .imm_i      (imm),
    .use_imm_i  (use_imm),
    .alu_op_i   (alu_op),
    .br_op_i    (br_op),
    .result_o   (alu_result),
    .br_taken_o (br_taken)
  );

endmodule

//--- tb/rv_core_tb.sv
// --------------------
// Testbench for the multicycle RISC-V core
// Memory and manager models, ISA reference and output compare
// --------------------

`timescale 1ns/10ps
`include "rv_core_settings.svh"

module rv_core_tb;
  import rv_core_pkg::*;

  localparam int WAIT_LIMIT = 20000;
  localparam int MEM_WORDS  = 256;

  logic  clk;
  logic  reset;
  word_t imem_req_addr_o;
  logic  imem_req_val_o;
  logic  imem_req_rdy_i;
  word_t imem_resp_data_i;
  logic  imem_resp_val_i;
  logic  imem_resp_rdy_o;
  word_t mngr2proc_msg_i;
  logic  mngr2proc_val_i;
  logic  mngr2proc_rdy_o;
  word_t proc2mngr_msg_o;
  logic  proc2mngr_val_o;
  logic  proc2mngr_rdy_i;

  word_t       mem [MEM_WORDS];
  int          prog_len;
  word_t       end_pc;
  word_t       mngr_in [$];
  word_t       exp_out [$];
  word_t       exp_fetch [$];
  int          value_errors;
  int          other_errors;
  int          out_count;
  int          exp_total;
  int          src_idx;
  logic [31:0] lcg_state;
  logic        resp_pend;
  logic        resp_fire;
  logic        src_fire;
  logic        req_held;
  logic        out_held;
  word_t       held_addr;
  word_t       held_msg;

  rv_core i_dut (
    .clk              (clk),
    .reset            (reset),
    .imem_req_addr_o  (imem_req_addr_o),
    .imem_req_val_o   (imem_req_val_o),
    .imem_req_rdy_i   (imem_req_rdy_i),
    .imem_resp_data_i (imem_resp_data_i),
    .imem_resp_val_i  (imem_resp_val_i),
    .imem_resp_rdy_o  (imem_resp_rdy_o),
    .mngr2proc_msg_i  (mngr2proc_msg_i),
    .mngr2proc_val_i  (mngr2proc_val_i),
    .mngr2proc_rdy_o  (mngr2proc_rdy_o),
    .proc2mngr_msg_o  (proc2mngr_msg_o),
    .proc2mngr_val_o  (proc2mngr_val_o),
    .proc2mngr_rdy_i  (proc2mngr_rdy_i)
  );

  always #5 clk = ~clk;

  // --------------------
  // Compare tasks
  // --------------------

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // Roughly 70 percent chance of being ready or valid
  function automatic logic ready_draw();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:28] < 4'd11;
  endfunction

  // --------------------
  // Instruction encoders
  // --------------------

  function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_b(input int off, input reg_idx_t rs2, input reg_idx_t rs1,
                                  input logic [2:0] f3);
    logic [12:0] o;
    o = off[12:0];
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'h63};
  endfunction

  function automatic word_t enc_j(input int off, input reg_idx_t rd);
    logic [20:0] o;
    o = off[20:0];
    return {o[20], o[10:1], o[11], o[19:12], rd, 7'h6f};
  endfunction

  function automatic word_t csrr(input reg_idx_t rd);
    return enc_i(`RV_CSR_MNGR2PROC, 5'd0, 3'b010, rd, 7'h73);
  endfunction

  function automatic word_t csrw(input reg_idx_t rs);
    return enc_i(`RV_CSR_PROC2MNGR, rs, 3'b001, 5'd0, 7'h73);
  endfunction

  task automatic emit(input word_t w);
    mem[prog_len] = w;
    prog_len++;
  endtask

  task automatic build_program();
    logic [2:0] r_f3 [10];
    logic       r_alt [10];
    logic [2:0] i_f3 [6];
    logic [2:0] b_f3 [6];
    reg_idx_t   ra [3];
    reg_idx_t   rb [3];
    r_f3  = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5};
    r_alt = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    i_f3  = '{3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd3};
    b_f3  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    ra    = '{5'd1, 5'd2, 5'd1};
    rb    = '{5'd2, 5'd1, 5'd1};
    prog_len = 0;
    emit(csrr(5'd1));
    emit(csrr(5'd2));
    // Register-register ops in both operand orders
    for (int i = 0; i < 10; i++) begin
      emit(enc_r(r_alt[i] ? 7'h20 : 7'h00, 5'd2, 5'd1, r_f3[i], 5'd3));
      emit(csrw(5'd3));
      emit(enc_r(r_alt[i] ? 7'h20 : 7'h00, 5'd1, 5'd2, r_f3[i], 5'd3));
      emit(csrw(5'd3));
    end
    // Immediate ops with a negative immediate
    for (int i = 0; i < 6; i++) begin
      emit(enc_i(12'hffb, 5'd1, i_f3[i], 5'd3, 7'h13));
      emit(csrw(5'd3));
      emit(enc_i(12'hffb, 5'd2, i_f3[i], 5'd3, 7'h13));
      emit(csrw(5'd3));
    end
    emit(enc_i(12'h004, 5'd2, 3'd1, 5'd3, 7'h13));
    emit(csrw(5'd3));
    emit(enc_i(12'h003, 5'd2, 3'd5, 5'd3, 7'h13));
    emit(csrw(5'd3));
    emit(enc_i(12'h403, 5'd2, 3'd5, 5'd3, 7'h13));
    emit(csrw(5'd3));
    emit({20'habcde, 5'd3, 7'h37});
    emit(csrw(5'd3));
    // x0 stays zero
    emit(enc_i(12'h007, 5'd1, 3'd0, 5'd0, 7'h13));
    emit(csrw(5'd0));
    // x4 shows whether each branch type was taken
    for (int p = 0; p < 3; p++) begin
      for (int i = 0; i < 6; i++) begin
        emit(enc_i(12'h000, 5'd0, 3'd0, 5'd4, 7'h13));
        emit(enc_b(8, rb[p], ra[p], b_f3[i]));
        emit(enc_i(12'h001, 5'd0, 3'd0, 5'd4, 7'h13));
        emit(csrw(5'd4));
      end
    end
    // jal skips one instruction and links
    emit(enc_j(8, 5'd5));
    emit(enc_i(12'h009, 5'd0, 3'd0, 5'd6, 7'h13));
    emit(csrw(5'd5));
    emit(csrw(5'd6));
    // Counting loop
    emit(csrr(5'd7));
    emit(enc_i(12'h000, 5'd0, 3'd0, 5'd8, 7'h13));
    emit(enc_i(12'h001, 5'd8, 3'd0, 5'd8, 7'h13));
    emit(enc_i(12'hfff, 5'd7, 3'd0, 5'd7, 7'h13));
    emit(enc_b(-8, 5'd0, 5'd7, 3'd1));
    emit(csrw(5'd8));
    end_pc = `RV_RESET_PC + word_t'(prog_len * 4);
    emit(enc_j(0, 5'd0));
  endtask

  // --------------------
  // ISA reference
  // --------------------

  function automatic word_t ref_alu(input logic [2:0] f3, input logic alt, input word_t a,
                                    input word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic void run_reference();
    word_t r [32];
    word_t pc;
    word_t next_pc;
    word_t res;
    word_t a;
    word_t b;
    word_t w;
    word_t imm_i_v;
    word_t imm_b_v;
    word_t imm_j_v;
    inst_u iw;
    int    k;
    int    idx;
    logic  wr;
    logic  take;
    logic [2:0] f3;
    for (int i = 0; i < 32; i++) begin
      r[i] = '0;
    end
    pc = `RV_RESET_PC;
    k  = 0;
    for (int steps = 0; steps < 4000; steps++) begin
      exp_fetch.push_back(pc);
      idx = int'((pc - `RV_RESET_PC) >> 2);
      if (pc == end_pc || idx >= MEM_WORDS) begin
        break;
      end
      w       = mem[idx];
      iw      = w;
      f3      = iw.r_fmt.funct3;
      a       = r[iw.r_fmt.rs1];
      b       = r[iw.r_fmt.rs2];
      wr      = 1'b0;
      res     = '0;
      take    = 1'b0;
      next_pc = pc + 4;
      // Immediate bit positions as the ISA manual lists them
      imm_i_v = {{20{w[31]}}, w[31:20]};
      imm_b_v = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      imm_j_v = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      case (iw.r_fmt.opcode)
        7'h33: begin
          res = ref_alu(f3, iw.r_fmt.funct7[5], a, b);
          wr  = 1'b1;
        end
        7'h13: begin
          res = ref_alu(f3, f3 == 3'd5 && iw.i_fmt.imm12[10], a, imm_i_v);
          wr  = 1'b1;
        end
        7'h37: begin
          res = {iw.u_j_fmt.imm20, 12'h000};
          wr  = 1'b1;
        end
        7'h63: begin
          case (f3)
            3'd0:    take = (a == b);
            3'd1:    take = (a != b);
            3'd4:    take = ($signed(a) < $signed(b));
            3'd5:    take = ($signed(a) >= $signed(b));
            3'd6:    take = (a < b);
            3'd7:    take = (a >= b);
            default: take = 1'b0;
          endcase
          if (take) begin
            next_pc = pc + imm_b_v;
          end
        end
        7'h6f: begin
          res     = pc + 4;
          wr      = 1'b1;
          next_pc = pc + imm_j_v;
        end
        7'h73: begin
          if (f3 == 3'b010 && iw.i_fmt.imm12 == `RV_CSR_MNGR2PROC) begin
            res = mngr_in[k];
            k++;
            wr  = 1'b1;
          end else if (f3 == 3'b001 && iw.i_fmt.imm12 == `RV_CSR_PROC2MNGR) begin
            exp_out.push_back(a);
          end
        end
        default: ;
      endcase
      if (wr && iw.r_fmt.rd != 5'd0) begin
        r[iw.r_fmt.rd] = res;
      end
      pc = next_pc;
    end
  endfunction

  // --------------------
  // Stream models and compare
  // --------------------

  task automatic accept_fetch(input word_t addr);
    word_t exp;
    int    idx;
    exp = (exp_fetch.size() > 0) ? exp_fetch.pop_front() : end_pc;
    check_addr("imem_req_addr_o", addr, exp);
    idx = int'((addr - `RV_RESET_PC) >> 2);
    if (addr < `RV_RESET_PC || idx >= MEM_WORDS) begin
      other_errors++;
      $display("fetch at %0t went outside the program memory, address %h", $time, addr);
      imem_resp_data_i = '0;
    end else begin
      imem_resp_data_i = mem[idx];
    end
    resp_pend = 1'b1;
  endtask

  task automatic compare_output(input word_t msg);
    if (exp_out.size() == 0) begin
      other_errors++;
      $display("core sent an unexpected manager word %h at %0t", msg, $time);
    end else begin
      check_word("proc2mngr_msg_o", msg, exp_out.pop_front());
    end
    out_count++;
  endtask

  // Transfers happen at the next rising edge when val and rdy are high here
  always @(negedge clk) begin
    if (reset) begin
      imem_req_rdy_i  = 1'b0;
      imem_resp_val_i = 1'b0;
      mngr2proc_val_i = 1'b0;
      proc2mngr_rdy_i = 1'b0;
    end else begin
      if (resp_fire) begin
        imem_resp_val_i = 1'b0;
        resp_fire       = 1'b0;
      end
      if (resp_pend && !imem_resp_val_i) begin
        imem_resp_val_i = ready_draw();
      end
      if (imem_resp_val_i && imem_resp_rdy_o) begin
        resp_fire = 1'b1;
        resp_pend = 1'b0;
      end
      if (imem_req_val_o) begin
        if (req_held) begin
          check_addr("imem_req_addr_o while stalled", imem_req_addr_o, held_addr);
        end
        imem_req_rdy_i = ready_draw();
        req_held       = !imem_req_rdy_i;
        held_addr      = imem_req_addr_o;
        if (imem_req_rdy_i) begin
          accept_fetch(imem_req_addr_o);
        end
      end else begin
        if (req_held) begin
          other_errors++;
          $display("imem_req_val_o dropped at %0t before the request was accepted", $time);
        end
        imem_req_rdy_i = 1'b0;
        req_held       = 1'b0;
      end
      if (src_fire) begin
        mngr2proc_val_i = 1'b0;
        src_fire        = 1'b0;
      end
      if (src_idx < mngr_in.size() && !mngr2proc_val_i) begin
        mngr2proc_msg_i = mngr_in[src_idx];
        mngr2proc_val_i = ready_draw();
      end
      if (mngr2proc_val_i && mngr2proc_rdy_o) begin
        src_fire = 1'b1;
        src_idx++;
      end
      if (proc2mngr_val_o) begin
        if (out_held) begin
          check_word("proc2mngr_msg_o while stalled", proc2mngr_msg_o, held_msg);
        end
        proc2mngr_rdy_i = ready_draw();
        out_held        = !proc2mngr_rdy_i;
        held_msg        = proc2mngr_msg_o;
        if (proc2mngr_rdy_i) begin
          compare_output(proc2mngr_msg_o);
        end
      end else begin
        if (out_held) begin
          other_errors++;
          $display("proc2mngr_val_o dropped at %0t before the word was taken", $time);
        end
        proc2mngr_rdy_i = 1'b0;
        out_held        = 1'b0;
      end
    end
  end

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    int cycles;
    clk              = 1'b0;
    reset            = 1'b1;
    imem_req_rdy_i   = 1'b0;
    imem_resp_data_i = '0;
    imem_resp_val_i  = 1'b0;
    mngr2proc_msg_i  = '0;
    mngr2proc_val_i  = 1'b0;
    proc2mngr_rdy_i  = 1'b0;
    lcg_state        = 32'hc6ec_3af5;
    value_errors     = 0;
    other_errors     = 0;
    out_count        = 0;
    src_idx          = 0;
    resp_pend        = 1'b0;
    resp_fire        = 1'b0;
    src_fire         = 1'b0;
    req_held         = 1'b0;
    out_held         = 1'b0;
    // Unused words hold addi x0 no-ops tagged with their index
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = (word_t'(i) << 20) | 32'h0000_0013;
    end
    mngr_in = '{32'h0000_00f0, 32'hffff_ff85, 32'd5};
    build_program();
    run_reference();
    exp_total = exp_out.size();

    repeat (4) @(posedge clk);
    @(negedge clk);
    check_bit("imem_req_val_o", imem_req_val_o, 1'b0);
    check_bit("imem_resp_rdy_o", imem_resp_rdy_o, 1'b0);
    check_bit("mngr2proc_rdy_o", mngr2proc_rdy_o, 1'b0);
    check_bit("proc2mngr_val_o", proc2mngr_val_o, 1'b0);
    reset <= 1'b0;

    cycles = 0;
    while (out_count < exp_total && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (out_count < exp_total) begin
      other_errors++;
      $display("timed out with %0d of %0d manager words received", out_count, exp_total);
    end
    cycles = 0;
    while (exp_fetch.size() > 0 && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_fetch.size() > 0) begin
      other_errors++;
      $display("timed out with %0d expected fetches still missing", exp_fetch.size());
    end

    $display("value errors: %0d, other errors: %0d, outputs checked: %0d",
             value_errors, other_errors, out_count);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- rv_core.f
+incdir+logic
logic/rv_core_pkg.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_inst_decode.sv
logic/rv_core_ctrl.sv
logic/rv_core.sv
tb/rv_core_tb.sv
